//--- rtl/bus_pkg.sv
package bus_pkg;

  ////////////////////////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////////////////////////

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 64;
  localparam int WORD_BYTES = 8;

  ////////////////////////////////////////////////////////////
  // Memory map
  ////////////////////////////////////////////////////////////

  localparam logic [ADDR_W-1:0] MEM_BASE  = 32'h8000_0000;
  localparam int                MEM_WORDS = 1024;

  // Returned by the error responder on unmapped addresses
  localparam logic [DATA_W-1:0] ERR_VAL = 64'h0000_0000_BADC_AB1E;

  // Single-beat request, one per valid/ready transfer
  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } bus_rsp_t;

endpackage

//--- rtl/dbg_pkg.sv
package dbg_pkg;

  typedef enum logic {
    DMI_READ  = 1'b0,
    DMI_WRITE = 1'b1
  } dmi_op_e;

  // System bus register offsets in the debug module space
  typedef enum logic [6:0] {
    SBCS       = 7'h38,
    SBADDRESS0 = 7'h39,
    SBDATA0    = 7'h3C,
    SBDATA1    = 7'h3D
  } dbg_reg_e;

  // Low five bits of SBCS, sberror at bit 4
  typedef struct packed {
    logic sberror;
    logic sbbusy;
    logic sbreadonaddr;
    logic sbautoincrement;
    logic sbreadondata;
  } sbcs_t;

  // Address kept as plain bits so unknown offsets can be carried
  typedef struct packed {
    dmi_op_e     op;
    logic [6:0]  addr;
    logic [31:0] data;
  } dmi_req_t;

  typedef struct packed {
    logic [31:0] data;
    logic        err;
  } dmi_rsp_t;

endpackage

//--- rtl/dbg_sba.sv
`timescale 1ns/1ps

module dbg_sba (
  input  logic              clk_sys,
  input  logic              rst_n_i,
  input  logic              dmi_valid_i,
  input  dbg_pkg::dmi_req_t dmi_req_i,
  output logic              dmi_ready_o,
  output logic              dmi_rsp_valid_o,
  output dbg_pkg::dmi_rsp_t dmi_rsp_o,
  output logic              bus_valid_o,
  output bus_pkg::bus_req_t bus_req_o,
  input  logic              bus_ready_i,
  input  logic              bus_rsp_valid_i,
  input  bus_pkg::bus_rsp_t bus_rsp_i
);

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT
  } state_e;

  state_e                     state_q;
  dbg_pkg::sbcs_t             sbcs_q;
  logic [bus_pkg::ADDR_W-1:0] sbaddr_q;
  logic [31:0]                sbdata0_q;
  logic [31:0]                sbdata1_q;
  logic                       bus_we_q;
  logic                       rsp_valid_q;
  dbg_pkg::dmi_rsp_t          rsp_q;

  logic           dmi_fire;
  logic           is_write;
  logic           launch_rd;
  logic           launch_wr;
  logic           known;
  logic [31:0]    rdata;
  dbg_pkg::sbcs_t sbcs_w;

  assign dmi_ready_o = !sbcs_q.sbbusy;
  assign dmi_fire    = dmi_valid_i && dmi_ready_o;
  assign is_write    = (dmi_req_i.op == dbg_pkg::DMI_WRITE);
  assign sbcs_w      = dmi_req_i.data[4:0];

  ////////////////////////////////////////////////////////////
  // Register read decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    rdata = '0;
    known = 1'b1;
    case (dmi_req_i.addr)
      dbg_pkg::SBCS:       rdata = {27'd0, sbcs_q};
      dbg_pkg::SBADDRESS0: rdata = sbaddr_q;
      dbg_pkg::SBDATA0:    rdata = sbdata0_q;
      dbg_pkg::SBDATA1:    rdata = sbdata1_q;
      default:             known = 1'b0;
    endcase
  end

  // Bus access triggers
  assign launch_wr = dmi_fire && is_write && (dmi_req_i.addr == dbg_pkg::SBDATA0);
  assign launch_rd = dmi_fire &&
                     ((is_write && (dmi_req_i.addr == dbg_pkg::SBADDRESS0) &&
                       sbcs_q.sbreadonaddr) ||
                      (!is_write && (dmi_req_i.addr == dbg_pkg::SBDATA0) &&
                       sbcs_q.sbreadondata));

  ////////////////////////////////////////////////////////////
  // Registers and bus master FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      sbcs_q      <= '0;
      sbaddr_q    <= '0;
      sbdata0_q   <= '0;
      sbdata1_q   <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= dmi_fire;
      if (dmi_fire && is_write) begin
        case (dmi_req_i.addr)
          dbg_pkg::SBCS: begin
            sbcs_q.sbreadonaddr    <= sbcs_w.sbreadonaddr;
            sbcs_q.sbautoincrement <= sbcs_w.sbautoincrement;
            sbcs_q.sbreadondata    <= sbcs_w.sbreadondata;
            // sberror is write-one-to-clear
            if (sbcs_w.sberror) begin
              sbcs_q.sberror <= 1'b0;
            end
          end
          dbg_pkg::SBADDRESS0: sbaddr_q <= dmi_req_i.data;
          dbg_pkg::SBDATA0:    sbdata0_q <= dmi_req_i.data;
          dbg_pkg::SBDATA1:    sbdata1_q <= dmi_req_i.data;
          default: ;
        endcase
      end
      case (state_q)
        IDLE: begin
          if (launch_rd || launch_wr) begin
            state_q       <= REQ;
            sbcs_q.sbbusy <= 1'b1;
          end
        end
        REQ: begin
          if (bus_ready_i) begin
            state_q <= WAIT;
          end
        end
        WAIT: begin
          if (bus_rsp_valid_i) begin
            state_q       <= IDLE;
            sbcs_q.sbbusy <= 1'b0;
            if (bus_rsp_i.err) begin
              sbcs_q.sberror <= 1'b1;
            end
            // Error reads still land ERR_VAL in the data registers
            if (!bus_we_q) begin
              {sbdata1_q, sbdata0_q} <= bus_rsp_i.rdata;
            end
            if (sbcs_q.sbautoincrement) begin
              sbaddr_q <= sbaddr_q + bus_pkg::WORD_BYTES;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Every DMI command is answered, writes with zero data
  always_ff @(posedge clk_sys) begin
    if (dmi_fire) begin
      rsp_q.data <= is_write ? 32'd0 : rdata;
      rsp_q.err  <= !known;
    end
    if (launch_rd || launch_wr) begin
      bus_we_q <= launch_wr;
    end
  end

  assign dmi_rsp_valid_o = rsp_valid_q;
  assign dmi_rsp_o       = rsp_q;

  // Registers are frozen while busy, so the request holds steady
  assign bus_valid_o = (state_q == REQ);
  assign bus_req_o   = '{we: bus_we_q, addr: sbaddr_q, wdata: {sbdata1_q, sbdata0_q}};

endmodule

//--- rtl/burst_loader.sv
`timescale 1ns/1ps

module burst_loader (
  input  logic                       clk_sys,
  input  logic                       rst_n_i,
  input  logic                       cmd_valid_i,
  input  logic [bus_pkg::ADDR_W-1:0] cmd_addr_i,
  input  logic [15:0]                cmd_len_i,
  output logic                       cmd_ready_o,
  input  logic                       word_valid_i,
  input  logic [bus_pkg::DATA_W-1:0] word_i,
  output logic                       word_ready_o,
  output logic                       done_o,
  output logic                       done_err_o,
  output logic                       bus_valid_o,
  output bus_pkg::bus_req_t          bus_req_o,
  input  logic                       bus_ready_i,
  input  logic                       bus_rsp_valid_i,
  input  bus_pkg::bus_rsp_t          bus_rsp_i
);

  typedef enum logic [1:0] {
    IDLE,
    SEND,
    WAIT
  } state_e;

  state_e                     state_q;
  logic [bus_pkg::ADDR_W-1:0] addr_q;
  logic [15:0]                cnt_q;
  logic                       err_q;
  logic                       done_q;
  logic                       done_err_q;

  logic cmd_fire;
  logic word_fire;

  assign cmd_ready_o = (state_q == IDLE);
  assign cmd_fire    = cmd_valid_i && cmd_ready_o;

  // A word is taken in the same cycle the bus takes its write
  assign word_ready_o = (state_q == SEND) && bus_ready_i;
  assign word_fire    = word_valid_i && word_ready_o;

  assign bus_valid_o = (state_q == SEND) && word_valid_i;
  assign bus_req_o   = '{we: 1'b1, addr: addr_q, wdata: word_i};

  always_ff @(posedge clk_sys or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= IDLE;
      err_q      <= 1'b0;
      done_q     <= 1'b0;
      done_err_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (cmd_fire) begin
            err_q <= 1'b0;
            // Empty burst finishes at once
            if (cmd_len_i == 16'd0) begin
              done_q     <= 1'b1;
              done_err_q <= 1'b0;
            end else begin
              state_q <= SEND;
            end
          end
        end
        SEND: begin
          if (word_fire) begin
            state_q <= WAIT;
          end
        end
        WAIT: begin
          if (bus_rsp_valid_i) begin
            err_q <= err_q | bus_rsp_i.err;
            if (cnt_q == 16'd0) begin
              state_q    <= IDLE;
              done_q     <= 1'b1;
              done_err_q <= err_q | bus_rsp_i.err;
            end else begin
              state_q <= SEND;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Address and remaining-word count
  always_ff @(posedge clk_sys) begin
    if (cmd_fire) begin
      addr_q <= cmd_addr_i;
      cnt_q  <= cmd_len_i;
    end else if (word_fire) begin
      addr_q <= addr_q + bus_pkg::WORD_BYTES;
      cnt_q  <= cnt_q - 16'd1;
    end
  end

  assign done_o     = done_q;
  assign done_err_o = done_err_q;

endmodule

//--- rtl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
  input  logic              clk_sys,
  input  logic              rst_n_i,
  input  logic              m0_valid_i,
  input  bus_pkg::bus_req_t m0_req_i,
  output logic              m0_ready_o,
  output logic              m0_rsp_valid_o,
  output bus_pkg::bus_rsp_t m0_rsp_o,
  input  logic              m1_valid_i,
  input  bus_pkg::bus_req_t m1_req_i,
  output logic              m1_ready_o,
  output logic              m1_rsp_valid_o,
  output bus_pkg::bus_rsp_t m1_rsp_o,
  output logic              mem_valid_o,
  output bus_pkg::bus_req_t mem_req_o,
  input  logic              mem_rsp_valid_i,
  input  bus_pkg::bus_rsp_t mem_rsp_i
);

  // Set when m1 wins a tie
  logic       prio_q;
  // Master whose request is in the memory this cycle
  logic       owner_q;
  logic [1:0] gnt;

  assign gnt[0] = m0_valid_i && (!m1_valid_i || !prio_q);
  assign gnt[1] = m1_valid_i && (!m0_valid_i || prio_q);

  // Memory never stalls, so a grant is the ready
  assign m0_ready_o  = gnt[0];
  assign m1_ready_o  = gnt[1];
  assign mem_valid_o = |gnt;
  assign mem_req_o   = gnt[1] ? m1_req_i : m0_req_i;

  always_ff @(posedge clk_sys or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prio_q  <= 1'b0;
      owner_q <= 1'b0;
    end else if (mem_valid_o) begin
      prio_q  <= gnt[0];
      owner_q <= gnt[1];
    end
  end

  // Response comes back one cycle after the grant
  assign m0_rsp_valid_o = mem_rsp_valid_i && !owner_q;
  assign m1_rsp_valid_o = mem_rsp_valid_i && owner_q;
  assign m0_rsp_o       = mem_rsp_i;
  assign m1_rsp_o       = mem_rsp_i;

endmodule

//--- rtl/mem_region.sv
`timescale 1ns/1ps

module mem_region (
  input  logic              clk_sys,
  input  logic              rst_n_i,
  input  logic              req_valid_i,
  input  bus_pkg::bus_req_t req_i,
  output logic              rsp_valid_o,
  output bus_pkg::bus_rsp_t rsp_o
);

  logic [bus_pkg::DATA_W-1:0] mem [bus_pkg::MEM_WORDS];

  logic [bus_pkg::ADDR_W-1:0]            offset;
  logic                                  mapped;
  logic [$clog2(bus_pkg::MEM_WORDS)-1:0] idx;
  logic                                  rsp_valid_q;
  bus_pkg::bus_rsp_t                     rsp_q;

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////

  assign offset = req_i.addr - bus_pkg::MEM_BASE;
  assign mapped = (req_i.addr >= bus_pkg::MEM_BASE) &&
                  (offset < bus_pkg::MEM_WORDS * bus_pkg::WORD_BYTES);
  // Word index, byte lane bits dropped
  assign idx    = offset[$clog2(bus_pkg::WORD_BYTES) +: $clog2(bus_pkg::MEM_WORDS)];

  always_ff @(posedge clk_sys or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;
    end
  end

  // SRAM and error responder, unmapped writes go nowhere
  always_ff @(posedge clk_sys) begin
    if (req_valid_i) begin
      if (mapped && req_i.we) begin
        mem[idx] <= req_i.wdata;
      end
      rsp_q.rdata <= mapped ? mem[idx] : bus_pkg::ERR_VAL;
      rsp_q.err   <= !mapped;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

//--- rtl/preload_top.sv
`timescale 1ns/1ps

module preload_top (
  input  logic                       clk_sys,
  input  logic                       rst_n_i,
  input  logic                       dmi_valid_i,
  input  dbg_pkg::dmi_req_t          dmi_req_i,
  output logic                       dmi_ready_o,
  output logic                       dmi_rsp_valid_o,
  output dbg_pkg::dmi_rsp_t          dmi_rsp_o,
  input  logic                       cmd_valid_i,
  input  logic [bus_pkg::ADDR_W-1:0] cmd_addr_i,
  input  logic [15:0]                cmd_len_i,
  output logic                       cmd_ready_o,
  input  logic                       word_valid_i,
  input  logic [bus_pkg::DATA_W-1:0] word_i,
  output logic                       word_ready_o,
  output logic                       done_o,
  output logic                       done_err_o
);

  // Debug port on m0, loader on m1
  logic              sba_valid;
  bus_pkg::bus_req_t sba_req;
  logic              sba_ready;
  logic              sba_rsp_valid;
  bus_pkg::bus_rsp_t sba_rsp;
  logic              ldr_valid;
  bus_pkg::bus_req_t ldr_req;
  logic              ldr_ready;
  logic              ldr_rsp_valid;
  bus_pkg::bus_rsp_t ldr_rsp;
  logic              mem_valid;
  bus_pkg::bus_req_t mem_req;
  logic              mem_rsp_valid;
  bus_pkg::bus_rsp_t mem_rsp;

  dbg_sba i_dbg_sba (
    .clk_sys         ( clk_sys         ),
    .rst_n_i         ( rst_n_i         ),
    .dmi_valid_i     ( dmi_valid_i     ),
    .dmi_req_i       ( dmi_req_i       ),
    .dmi_ready_o     ( dmi_ready_o     ),
    .dmi_rsp_valid_o ( dmi_rsp_valid_o ),
    .dmi_rsp_o       ( dmi_rsp_o       ),
    .bus_valid_o     ( sba_valid       ),
    .bus_req_o       ( sba_req         ),
    .bus_ready_i     ( sba_ready       ),
    .bus_rsp_valid_i ( sba_rsp_valid   ),
    .bus_rsp_i       ( sba_rsp         )
  );

  burst_loader i_burst_loader (
    .clk_sys         ( clk_sys         ),
    .rst_n_i         ( rst_n_i         ),
    .cmd_valid_i     ( cmd_valid_i     ),
    .cmd_addr_i      ( cmd_addr_i      ),
    .cmd_len_i       ( cmd_len_i       ),
    .cmd_ready_o     ( cmd_ready_o     ),
    .word_valid_i    ( word_valid_i    ),
    .word_i          ( word_i          ),
    .word_ready_o    ( word_ready_o    ),
    .done_o          ( done_o          ),
    .done_err_o      ( done_err_o      ),
    .bus_valid_o     ( ldr_valid       ),
    .bus_req_o       ( ldr_req         ),
    .bus_ready_i     ( ldr_ready       ),
    .bus_rsp_valid_i ( ldr_rsp_valid   ),
    .bus_rsp_i       ( ldr_rsp         )
  );

  bus_arbiter i_bus_arbiter (
    .clk_sys         ( clk_sys         ),
    .rst_n_i         ( rst_n_i         ),
    .m0_valid_i      ( sba_valid       ),
    .m0_req_i        ( sba_req         ),
    .m0_ready_o      ( sba_ready       ),
    .m0_rsp_valid_o  ( sba_rsp_valid   ),
    .m0_rsp_o        ( sba_rsp         ),
    .m1_valid_i      ( ldr_valid       ),
    .m1_req_i        ( ldr_req         ),
    .m1_ready_o      ( ldr_ready       ),
    .m1_rsp_valid_o  ( ldr_rsp_valid   ),
    .m1_rsp_o        ( ldr_rsp         ),
    .mem_valid_o     ( mem_valid       ),
    .mem_req_o       ( mem_req         ),
    .mem_rsp_valid_i ( mem_rsp_valid   ),
    .mem_rsp_i       ( mem_rsp         )
  );

  mem_region i_mem_region (
    .clk_sys         ( clk_sys         ),
    .rst_n_i         ( rst_n_i         ),
    .req_valid_i     ( mem_valid       ),
    .req_i           ( mem_req         ),
    .rsp_valid_o     ( mem_rsp_valid   ),
    .rsp_o           ( mem_rsp         )
  );

endmodule

//--- bench/preload_properties.sv
`timescale 1ns/1ps

module preload_properties (
  input logic              clk_sys,
  input logic              rst_n_i,
  input logic              m0_valid_i,
  input bus_pkg::bus_req_t m0_req_i,
  input logic              m0_ready_o,
  input logic              m0_rsp_valid_o,
  input logic              m1_valid_i,
  input bus_pkg::bus_req_t m1_req_i,
  input logic              m1_ready_o,
  input logic              m1_rsp_valid_o,
  input logic              mem_valid_o,
  input logic              mem_rsp_valid_i
);

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  m0_hold: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
    m0_valid_i && !m0_ready_o |=> m0_valid_i && $stable(m0_req_i))
    else $error("m0 request changed before it was accepted");

  m1_hold: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
    m1_valid_i && !m1_ready_o |=> m1_valid_i && $stable(m1_req_i))
    else $error("m1 request changed before it was accepted");

  // At most one grant, and only when memory sees a request
  gnt_onehot: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
    mem_valid_o == $onehot({m0_ready_o, m1_ready_o}))
    else $error("arbiter grant is not one-hot");

  ////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////

  m0_rsp: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
    m0_valid_i && m0_ready_o |=> m0_rsp_valid_o)
    else $error("m0 response missing one cycle after grant");

  m1_rsp: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
    m1_valid_i && m1_ready_o |=> m1_rsp_valid_o)
    else $error("m1 response missing one cycle after grant");

  rsp_follows: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
    mem_rsp_valid_i |-> $past(mem_valid_o))
    else $error("memory response without a request");

endmodule

bind bus_arbiter preload_properties u_props (.*);

//--- bench/tb_preload.sv
`timescale 1ns/1ps

module tb_preload;

  localparam int CLK_HALF = 2;
  localparam int MARGIN   = 4;
  // Rough cycles per test in run order
  localparam int BUDGET   = 20 + 300 + 250 + 60 + 80 + 400;

  // SBCS field positions
  localparam logic [31:0] SB_RDONDATA = 32'h01;
  localparam logic [31:0] SB_AUTOINC  = 32'h02;
  localparam logic [31:0] SB_RDONADDR = 32'h04;
  localparam logic [31:0] SB_ERROR    = 32'h10;
  localparam logic [31:0] BASE        = bus_pkg::MEM_BASE;

  logic              clk_sys;
  logic              rst_n_i;
  logic              dmi_valid_i;
  dbg_pkg::dmi_req_t dmi_req_i;
  logic              dmi_ready_o;
  logic              dmi_rsp_valid_o;
  dbg_pkg::dmi_rsp_t dmi_rsp_o;
  logic              cmd_valid_i;
  logic [31:0]       cmd_addr_i;
  logic [15:0]       cmd_len_i;
  logic              cmd_ready_o;
  logic              word_valid_i;
  logic [63:0]       word_i;
  logic              word_ready_o;
  logic              done_o;
  logic              done_err_o;

  logic [31:0] lfsr_state;
  logic [63:0] burst_words [32];
  logic [63:0] dbg_words [16];
  string       cur_test;
  int          n_tests;
  int          n_checks;
  int          n_errors;
  int          errs_before;

  preload_top UUT (.*);

  initial begin
    clk_sys = 1'b0;
    forever #CLK_HALF clk_sys = ~clk_sys;
  end

  initial begin
    repeat (BUDGET * MARGIN) @(posedge clk_sys);
    $display("Timeout: the tests did not finish within %0d cycles", BUDGET * MARGIN);
    $display("Something failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit
  task automatic next_word(output logic [63:0] w);
    w = '0;
    for (int b = 0; b < 64; b++) begin
      w          = {w[62:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic check(input logic [63:0] exp, input logic [63:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("FAIL %s expected %h actual %h", cur_test, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    errs_before = n_errors;
  endtask

  task automatic end_test();
    n_tests++;
    $display("%s done, %0d errors", cur_test, n_errors - errs_before);
  endtask

  // Returns one rising edge plus 1 ns after the response
  task automatic dmi_xfer(input dbg_pkg::dmi_op_e kind, input logic [6:0] reg_addr,
                          input logic [31:0] wdata, output dbg_pkg::dmi_rsp_t rsp);
    dmi_req_i   = '{op: kind, addr: reg_addr, data: wdata};
    dmi_valid_i = 1'b1;
    @(negedge clk_sys);
    while (!dmi_ready_o) @(negedge clk_sys);
    @(posedge clk_sys);
    #1;
    dmi_valid_i = 1'b0;
    @(negedge clk_sys);
    while (!dmi_rsp_valid_o) @(negedge clk_sys);
    rsp = dmi_rsp_o;
    @(posedge clk_sys);
    #1;
  endtask

  task automatic dmi_write(input logic [6:0] reg_addr, input logic [31:0] wdata);
    dbg_pkg::dmi_rsp_t rsp;
    dmi_xfer(dbg_pkg::DMI_WRITE, reg_addr, wdata, rsp);
    check(64'd0, 64'(rsp.err));
  endtask

  task automatic dmi_read(input logic [6:0] reg_addr, output logic [31:0] rdata);
    dbg_pkg::dmi_rsp_t rsp;
    dmi_xfer(dbg_pkg::DMI_READ, reg_addr, 32'd0, rsp);
    check(64'd0, 64'(rsp.err));
    rdata = rsp.data;
  endtask

  task automatic write_word(input logic [63:0] w);
    dmi_write(dbg_pkg::SBDATA1, w[63:32]);
    dmi_write(dbg_pkg::SBDATA0, w[31:0]);
  endtask

  // Needs sbreadonaddr set and sbreadondata clear
  task automatic read_word(input logic [31:0] addr, output logic [63:0] w);
    logic [31:0] hi;
    logic [31:0] lo;
    dmi_write(dbg_pkg::SBADDRESS0, addr);
    dmi_read(dbg_pkg::SBDATA1, hi);
    dmi_read(dbg_pkg::SBDATA0, lo);
    w = {hi, lo};
  endtask

  task automatic run_burst(input logic [31:0] addr, input int len, output logic err);
    cmd_addr_i  = addr;
    cmd_len_i   = 16'(len);
    cmd_valid_i = 1'b1;
    @(negedge clk_sys);
    while (!cmd_ready_o) @(negedge clk_sys);
    @(posedge clk_sys);
    #1;
    cmd_valid_i = 1'b0;
    for (int i = 0; i < len; i++) begin
      word_i       = burst_words[i];
      word_valid_i = 1'b1;
      @(negedge clk_sys);
      if (i == 0) begin
        check(64'd0, 64'(cmd_ready_o));
      end else begin
        // Previous write still outstanding
        check(64'd0, 64'(word_ready_o));
      end
      while (!word_ready_o) @(negedge clk_sys);
      @(posedge clk_sys);
      #1;
    end
    word_valid_i = 1'b0;
    @(negedge clk_sys);
    while (!done_o) @(negedge clk_sys);
    err = done_err_o;
    check(64'd1, 64'(cmd_ready_o));
    @(posedge clk_sys);
    #1;
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    logic [31:0]       val;
    dbg_pkg::dmi_rsp_t rsp;
    start_test("reset_state");
    repeat (5) begin
      @(negedge clk_sys);
      check(64'd0, 64'(done_o));
      check(64'd0, 64'(dmi_rsp_valid_o));
      check(64'd1, 64'(dmi_ready_o));
      check(64'd1, 64'(cmd_ready_o));
      check(64'd0, 64'(word_ready_o));
    end
    @(posedge clk_sys);
    #1;
    dmi_read(dbg_pkg::SBCS, val);
    check(64'd0, 64'(val));
    // Offset with no register behind it
    dmi_xfer(dbg_pkg::DMI_READ, 7'h10, 32'd0, rsp);
    check(64'd1, 64'(rsp.err));
    check(64'd0, 64'(rsp.data));
    end_test();
  endtask

  task automatic test_burst_readback();
    logic        err;
    logic [31:0] hi;
    logic [31:0] lo;
    start_test("burst_readback");
    for (int i = 0; i < 20; i++)
      next_word(burst_words[i]);
    run_burst(BASE, 20, err);
    check(64'd0, 64'(err));
    dmi_write(dbg_pkg::SBCS, SB_RDONADDR | SB_AUTOINC | SB_RDONDATA);
    // Address write primes the first read
    dmi_write(dbg_pkg::SBADDRESS0, BASE);
    for (int i = 0; i < 20; i++) begin
      dmi_read(dbg_pkg::SBDATA1, hi);
      dmi_read(dbg_pkg::SBDATA0, lo);
      check(burst_words[i], {hi, lo});
    end
    end_test();
  endtask

  task automatic test_dbg_autoinc();
    logic [31:0] addr;
    logic [31:0] val;
    logic [63:0] w;
    start_test("dbg_autoinc");
    addr = BASE + 32'h400;
    dmi_write(dbg_pkg::SBCS, SB_AUTOINC);
    dmi_write(dbg_pkg::SBADDRESS0, addr);
    for (int i = 0; i < 8; i++) begin
      next_word(dbg_words[i]);
      write_word(dbg_words[i]);
    end
    dmi_read(dbg_pkg::SBADDRESS0, val);
    check(64'(addr + 32'd64), 64'(val));
    dmi_write(dbg_pkg::SBCS, SB_RDONADDR);
    for (int i = 0; i < 8; i++) begin
      read_word(addr + 32'(i * 8), w);
      check(dbg_words[i], w);
    end
    end_test();
  endtask

  task automatic test_unmapped_dbg();
    logic [31:0] val;
    start_test("unmapped_dbg");
    dmi_write(dbg_pkg::SBCS, SB_RDONADDR);
    dmi_write(dbg_pkg::SBADDRESS0, 32'h0000_1000);
    // Port refuses commands while the bus read is in flight
    @(negedge clk_sys);
    check(64'd0, 64'(dmi_ready_o));
    @(posedge clk_sys);
    #1;
    dmi_read(dbg_pkg::SBDATA0, val);
    check(64'hBADC_AB1E, 64'(val));
    dmi_read(dbg_pkg::SBDATA1, val);
    check(64'd0, 64'(val));
    dmi_read(dbg_pkg::SBCS, val);
    check(64'(SB_ERROR | SB_RDONADDR), 64'(val));
    dmi_write(dbg_pkg::SBCS, SB_ERROR | SB_RDONADDR);
    dmi_read(dbg_pkg::SBCS, val);
    check(64'(SB_RDONADDR), 64'(val));
    end_test();
  endtask

  task automatic test_unmapped_burst();
    logic [31:0] addr;
    logic [63:0] w;
    logic        err;
    start_test("unmapped_burst");
    // Last two SRAM words and two past the end
    addr = BASE + 32'((bus_pkg::MEM_WORDS - 2) * bus_pkg::WORD_BYTES);
    for (int i = 0; i < 4; i++)
      next_word(burst_words[i]);
    run_burst(addr, 4, err);
    check(64'd1, 64'(err));
    dmi_write(dbg_pkg::SBCS, SB_RDONADDR);
    for (int i = 0; i < 2; i++) begin
      read_word(addr + 32'(i * 8), w);
      check(burst_words[i], w);
    end
    end_test();
  endtask

  task automatic test_concurrent();
    logic [31:0] ldr_base;
    logic [31:0] dbg_base;
    logic [63:0] w;
    logic        err;
    start_test("concurrent");
    ldr_base = BASE + 32'h1000;
    dbg_base = BASE + 32'h1800;
    for (int i = 0; i < 12; i++)
      next_word(burst_words[i]);
    for (int i = 0; i < 6; i++)
      next_word(dbg_words[i]);
    fork
      run_burst(ldr_base, 12, err);
      begin
        dmi_write(dbg_pkg::SBCS, SB_AUTOINC);
        dmi_write(dbg_pkg::SBADDRESS0, dbg_base);
        for (int i = 0; i < 6; i++)
          write_word(dbg_words[i]);
      end
    join
    check(64'd0, 64'(err));
    dmi_write(dbg_pkg::SBCS, SB_RDONADDR);
    for (int i = 0; i < 12; i++) begin
      read_word(ldr_base + 32'(i * 8), w);
      check(burst_words[i], w);
    end
    for (int i = 0; i < 6; i++) begin
      read_word(dbg_base + 32'(i * 8), w);
      check(dbg_words[i], w);
    end
    end_test();
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n_i      = 1'b0;
    dmi_valid_i  = 1'b0;
    dmi_req_i    = '0;
    cmd_valid_i  = 1'b0;
    cmd_addr_i   = '0;
    cmd_len_i    = '0;
    word_valid_i = 1'b0;
    word_i       = '0;
    lfsr_state   = 32'hb08;
    n_tests      = 0;
    n_checks     = 0;
    n_errors     = 0;
    repeat (4) @(posedge clk_sys);
    #1;
    rst_n_i = 1'b1;
    test_reset_state();
    test_burst_readback();
    test_dbg_autoinc();
    test_unmapped_dbg();
    test_unmapped_burst();
    test_concurrent();
    $display("Tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- tb.f
rtl/bus_pkg.sv
rtl/dbg_pkg.sv
rtl/dbg_sba.sv
rtl/burst_loader.sv
rtl/bus_arbiter.sv
rtl/mem_region.sv
rtl/preload_top.sv
bench/preload_properties.sv
bench/tb_preload.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the preload testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f tb.f --top-module tb_preload -o tb_preload_sim

status=0
./obj_dir/tb_preload_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "Everything OK" sim.log; then
  echo "Simulation passed"
  exit 0
fi

echo "Simulation did not pass, exit status $status"
exit 1
